// File: noc_config.svh
/*
 * NoC router configuration
 * Port count, VC count, buffer depth and flit field widths
 */
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Router ports West, East and Local
`define NOC_NUM_PORTS 3
`define NOC_NUM_VC    2
// Flit slots per VC and the credits per output VC
`define NOC_VC_DEPTH  2

`define NOC_DATA_W    12
`define NOC_PORT_W    2
`define NOC_TAG_W     10

`endif

// File: noc_flit_pkg.sv
/*
 * Flit types
 * A flit word carries a last bit, its VC id and a data field that is
 * read as head fields on the first flit and as payload on later flits
 */
`include "noc_config.svh"

package noc_flit_pkg;

  // Head view of the data field
  typedef struct packed {
    logic [`NOC_PORT_W-1:0] dst_port;
    logic [`NOC_TAG_W-1:0]  tag;
  } flit_head_t;

  typedef union packed {
    flit_head_t             head;
    logic [`NOC_DATA_W-1:0] payload;
  } flit_data_u;

  typedef struct packed {
    logic       last;
    logic       vc_id;
    flit_data_u data;
  } flit_t;

endpackage

// File: noc_route_pkg.sv
/*
 * Routing types
 * Port directions, VC ids and one-hot port vectors
 */
`include "noc_config.svh"

package noc_route_pkg;

  typedef enum logic [`NOC_PORT_W-1:0] {
    WEST  = 2'd0,
    EAST  = 2'd1,
    LOCAL = 2'd2
  } port_e;

  typedef logic [$clog2(`NOC_NUM_VC)-1:0] vc_id_t;

  // One bit per router port
  typedef logic [`NOC_NUM_PORTS-1:0] port_oh_t;

endpackage

// File: vc_input_port.sv
/*
 * Router input port
 * One FIFO per VC, route hold for body flits, round-robin choice of one VC
 * per packet and a credit return for every flit read
 */
`timescale 1ns/1ps
`include "noc_config.svh"

module vc_input_port (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    data_valid_i,
  input  noc_flit_pkg::flit_t     data_i,
  input  logic                    read_i,
  output logic                    req_valid_o,
  output noc_route_pkg::port_oh_t req_port_oh_o,
  output logic                    req_last_o,
  output noc_flit_pkg::flit_t     head_flit_o,
  output logic                    credit_valid_o,
  output noc_route_pkg::vc_id_t   credit_id_o
);

  localparam int unsigned ptr_w = (`NOC_VC_DEPTH > 1) ? $clog2(`NOC_VC_DEPTH) : 1;
  localparam int unsigned cnt_w = $clog2(`NOC_VC_DEPTH + 1);

  logic [`NOC_NUM_VC-1:0]  not_empty;
  noc_flit_pkg::flit_t     front [`NOC_NUM_VC];
  noc_route_pkg::port_oh_t vc_route [`NOC_NUM_VC];

  logic                    pkt_active_q;
  noc_route_pkg::vc_id_t   held_vc_q;
  noc_route_pkg::vc_id_t   rr_ptr_q;
  noc_route_pkg::vc_id_t   pick_vc;
  noc_route_pkg::vc_id_t   cur_vc;
  noc_flit_pkg::flit_t     cur_flit;
  noc_route_pkg::port_e    head_dst;
  noc_route_pkg::port_oh_t head_port_oh;
  logic                    credit_valid_q;
  noc_route_pkg::vc_id_t   credit_id_q;

  ////////////////////////////////////////
  // VC buffers
  ////////////////////////////////////////

  for (genvar v = 0; v < `NOC_NUM_VC; v++) begin : gen_vc
    noc_flit_pkg::flit_t     mem_q [`NOC_VC_DEPTH];
    logic [ptr_w-1:0]        wr_ptr_q;
    logic [ptr_w-1:0]        rd_ptr_q;
    logic [cnt_w-1:0]        count_q;
    noc_route_pkg::port_oh_t route_q;
    logic                    wr_en;
    logic                    rd_en;

    assign wr_en = data_valid_i && (data_i.vc_id == noc_route_pkg::vc_id_t'(v));
    assign rd_en = read_i && (cur_vc == noc_route_pkg::vc_id_t'(v));

    assign not_empty[v] = (count_q != '0);
    assign front[v]     = mem_q[rd_ptr_q];
    assign vc_route[v]  = route_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr_q <= (wr_ptr_q == ptr_w'(`NOC_VC_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (rd_en) begin
          rd_ptr_q <= (rd_ptr_q == ptr_w'(`NOC_VC_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        count_q <= count_q + cnt_w'(wr_en) - cnt_w'(rd_en);
      end
    end

    // Head flit route is kept for the rest of the packet
    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        mem_q[wr_ptr_q] <= data_i;
      end
      if (rd_en && !pkt_active_q) begin
        route_q <= head_port_oh;
      end
    end

    // Upstream must hold a credit for every flit it sends
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wr_en |-> (count_q < cnt_w'(`NOC_VC_DEPTH)));
  end

  ////////////////////////////////////////
  // Local VC selection
  ////////////////////////////////////////

  // First non-empty VC at or after the pointer
  always_comb begin
    int idx;
    pick_vc = rr_ptr_q;
    for (int k = `NOC_NUM_VC - 1; k >= 0; k--) begin
      idx = (int'(rr_ptr_q) + k) % `NOC_NUM_VC;
      if (not_empty[idx]) begin
        pick_vc = noc_route_pkg::vc_id_t'(idx);
      end
    end
  end

  assign cur_vc       = pkt_active_q ? held_vc_q : pick_vc;
  assign cur_flit     = front[cur_vc];
  assign head_dst     = noc_route_pkg::port_e'(cur_flit.data.head.dst_port);
  assign head_port_oh = noc_route_pkg::port_oh_t'(1) << head_dst;

  assign req_valid_o   = not_empty[cur_vc];
  assign req_port_oh_o = pkt_active_q ? vc_route[cur_vc] : head_port_oh;
  assign req_last_o    = cur_flit.last;
  assign head_flit_o   = cur_flit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pkt_active_q   <= 1'b0;
      held_vc_q      <= '0;
      rr_ptr_q       <= '0;
      credit_valid_q <= 1'b0;
      credit_id_q    <= '0;
    end else begin
      credit_valid_q <= read_i;
      if (read_i) begin
        credit_id_q <= cur_vc;
        if (cur_flit.last) begin
          pkt_active_q <= 1'b0;
          rr_ptr_q     <= (cur_vc == noc_route_pkg::vc_id_t'(`NOC_NUM_VC - 1)) ?
                          '0 : cur_vc + 1'b1;
        end else begin
          pkt_active_q <= 1'b1;
          held_vc_q    <= cur_vc;
        end
      end
    end
  end

  assign credit_valid_o = credit_valid_q;
  assign credit_id_o    = credit_id_q;

endmodule

// File: sw_alloc_global.sv
/*
 * Switch allocator
 * Round-robin choice of one input per output, held for a whole packet
 */
`timescale 1ns/1ps
`include "noc_config.svh"

module sw_alloc_global (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic [`NOC_NUM_PORTS-1:0]                     req_valid_i,
  input  noc_route_pkg::port_oh_t [`NOC_NUM_PORTS-1:0]  req_port_oh_i,
  input  logic [`NOC_NUM_PORTS-1:0]                     req_last_i,
  input  noc_route_pkg::port_oh_t                       sent_i,
  output logic [`NOC_NUM_PORTS-1:0]                     grant_valid_o,
  output noc_route_pkg::port_oh_t [`NOC_NUM_PORTS-1:0]  grant_in_oh_o,
  output noc_route_pkg::port_oh_t                       lock_o
);

  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_out
    noc_route_pkg::port_oh_t req;
    noc_route_pkg::port_oh_t rr_grant;
    noc_route_pkg::port_oh_t lock_in_q;
    logic                    lock_q;
    logic [`NOC_PORT_W-1:0]  ptr_q;
    logic [`NOC_PORT_W-1:0]  ptr_nx;
    logic                    grant_last;

    // Inputs whose current flit targets this output
    for (genvar i = 0; i < `NOC_NUM_PORTS; i++) begin : gen_req
      assign req[i] = req_valid_i[i] & req_port_oh_i[i][o];
    end

    always_comb begin
      int idx;
      rr_grant = '0;
      for (int k = `NOC_NUM_PORTS - 1; k >= 0; k--) begin
        idx = (int'(ptr_q) + k) % `NOC_NUM_PORTS;
        if (req[idx]) begin
          rr_grant = noc_route_pkg::port_oh_t'(1) << idx;
        end
      end
    end

    // A locked output only serves the input that owns the packet
    assign grant_in_oh_o[o] = lock_q ? (lock_in_q & req) : rr_grant;
    assign grant_valid_o[o] = |grant_in_oh_o[o];
    assign grant_last       = |(grant_in_oh_o[o] & req_last_i);
    assign lock_o[o]        = lock_q;

    // Pointer moves past the winner
    always_comb begin
      ptr_nx = ptr_q;
      for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
        if (grant_in_oh_o[o][i]) begin
          ptr_nx = (i == `NOC_NUM_PORTS - 1) ? '0 : `NOC_PORT_W'(i + 1);
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        lock_q    <= 1'b0;
        lock_in_q <= '0;
        ptr_q     <= '0;
      end else if (sent_i[o]) begin
        if (grant_last) begin
          lock_q <= 1'b0;
          ptr_q  <= ptr_nx;
        end else begin
          lock_q    <= 1'b1;
          lock_in_q <= grant_in_oh_o[o];
        end
      end
    end
  end

  // Each input feeds at most one output per cycle
  for (genvar i = 0; i < `NOC_NUM_PORTS; i++) begin : gen_in_chk
    noc_route_pkg::port_oh_t in_grant;

    for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_col
      assign in_grant[o] = grant_in_oh_o[o][i];
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(in_grant));
  end

endmodule

// File: out_credit_vc_sel.sv
/*
 * Output credit tracking
 * One saturating credit counter per downstream VC and the lowest free VC
 */
`timescale 1ns/1ps
`include "noc_config.svh"

module out_credit_vc_sel (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    credit_valid_i,
  input  noc_route_pkg::vc_id_t   credit_id_i,
  input  logic                    consume_i,
  input  noc_route_pkg::vc_id_t   consume_id_i,
  output logic                    vc_free_valid_o,
  output noc_route_pkg::vc_id_t   vc_free_id_o,
  output logic [`NOC_NUM_VC-1:0]  vc_not_full_o
);

  localparam int unsigned cnt_w = $clog2(`NOC_VC_DEPTH + 1);

  ////////////////////////////////////////
  // Credit counters
  ////////////////////////////////////////

  for (genvar v = 0; v < `NOC_NUM_VC; v++) begin : gen_vc
    logic [cnt_w-1:0] cnt_q;
    logic             inc;
    logic             dec;

    assign inc = credit_valid_i && (credit_id_i == noc_route_pkg::vc_id_t'(v));
    assign dec = consume_i && (consume_id_i == noc_route_pkg::vc_id_t'(v));

    // Downstream buffers start empty so the counters start full
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q <= cnt_w'(`NOC_VC_DEPTH);
      end else if (inc && !dec && (cnt_q != cnt_w'(`NOC_VC_DEPTH))) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (dec && !inc && (cnt_q != '0)) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    assign vc_not_full_o[v] = (cnt_q != '0);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dec |-> (cnt_q != '0));

    // Downstream never returns more credits than it has slots
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (inc && !dec) |-> (cnt_q < cnt_w'(`NOC_VC_DEPTH)));
  end

  ////////////////////////////////////////
  // Free VC choice
  ////////////////////////////////////////

  always_comb begin
    vc_free_id_o = '0;
    for (int v = `NOC_NUM_VC - 1; v >= 0; v--) begin
      if (vc_not_full_o[v]) begin
        vc_free_id_o = noc_route_pkg::vc_id_t'(v);
      end
    end
  end

  assign vc_free_valid_o = |vc_not_full_o;

endmodule

// File: vc_router_switch.sv
/*
 * Switch stage
 * Combines grants and free VCs into send decisions, holds the output VC of
 * a packet and registers the crossbar result
 */
`timescale 1ns/1ps
`include "noc_config.svh"

module vc_router_switch (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic [`NOC_NUM_PORTS-1:0]                     grant_valid_i,
  input  noc_route_pkg::port_oh_t [`NOC_NUM_PORTS-1:0]  grant_in_oh_i,
  input  noc_route_pkg::port_oh_t                       lock_i,
  input  logic [`NOC_NUM_PORTS-1:0]                     vc_free_valid_i,
  input  noc_route_pkg::vc_id_t [`NOC_NUM_PORTS-1:0]    vc_free_id_i,
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0]    vc_not_full_i,
  input  noc_flit_pkg::flit_t [`NOC_NUM_PORTS-1:0]      head_flit_i,
  input  logic [`NOC_NUM_PORTS-1:0]                     req_last_i,
  output noc_route_pkg::port_oh_t                       sent_o,
  output noc_route_pkg::vc_id_t [`NOC_NUM_PORTS-1:0]    sent_vc_o,
  output logic [`NOC_NUM_PORTS-1:0]                     read_o,
  output logic [`NOC_NUM_PORTS-1:0]                     data_valid_o,
  output noc_flit_pkg::flit_t [`NOC_NUM_PORTS-1:0]      data_o
);

  // Winning input of each output that sends this cycle
  noc_route_pkg::port_oh_t [`NOC_NUM_PORTS-1:0] sent_in_oh;

  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_out
    noc_route_pkg::vc_id_t held_vc_q;
    noc_flit_pkg::flit_t   sel_flit;
    noc_flit_pkg::flit_t   flit_q;
    logic                  valid_q;
    logic                  can_send;
    logic                  sel_last;

    // Body flits follow the VC that their head flit took
    assign can_send     = lock_i[o] ? vc_not_full_i[o][held_vc_q] : vc_free_valid_i[o];
    assign sent_o[o]    = grant_valid_i[o] & can_send;
    assign sent_vc_o[o] = lock_i[o] ? held_vc_q : vc_free_id_i[o];
    assign sent_in_oh[o] = sent_o[o] ? grant_in_oh_i[o] : '0;
    assign sel_last     = |(grant_in_oh_i[o] & req_last_i);

    // Crossbar column with the VC field rewritten to the output VC
    always_comb begin
      sel_flit = '0;
      for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
        if (grant_in_oh_i[o][i]) begin
          sel_flit = head_flit_i[i];
        end
      end
      sel_flit.vc_id = sent_vc_o[o];
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        held_vc_q <= '0;
        valid_q   <= 1'b0;
      end else begin
        valid_q <= sent_o[o];
        if (sent_o[o] && !lock_i[o] && !sel_last) begin
          held_vc_q <= vc_free_id_i[o];
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (sent_o[o]) begin
        flit_q <= sel_flit;
      end
    end

    assign data_valid_o[o] = valid_q;
    assign data_o[o]       = flit_q;
  end

  ////////////////////////////////////////
  // Read strobes back to the inputs
  ////////////////////////////////////////

  always_comb begin
    read_o = '0;
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      read_o = read_o | sent_in_oh[o];
    end
  end

endmodule

// File: vc_router.sv
/*
 * Three-port wormhole VC router
 * Input buffers, switch allocation, output credit tracking and switch
 */
`timescale 1ns/1ps
`include "noc_config.svh"

module vc_router (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic [`NOC_NUM_PORTS-1:0]                    data_valid_i,
  input  noc_flit_pkg::flit_t [`NOC_NUM_PORTS-1:0]     data_i,
  input  logic [`NOC_NUM_PORTS-1:0]                    credit_valid_i,
  input  noc_route_pkg::vc_id_t [`NOC_NUM_PORTS-1:0]   credit_id_i,
  output logic [`NOC_NUM_PORTS-1:0]                    data_valid_o,
  output noc_flit_pkg::flit_t [`NOC_NUM_PORTS-1:0]     data_o,
  output logic [`NOC_NUM_PORTS-1:0]                    credit_valid_o,
  output noc_route_pkg::vc_id_t [`NOC_NUM_PORTS-1:0]   credit_id_o
);

  logic [`NOC_NUM_PORTS-1:0]                    req_valid;
  noc_route_pkg::port_oh_t [`NOC_NUM_PORTS-1:0] req_port_oh;
  logic [`NOC_NUM_PORTS-1:0]                    req_last;
  noc_flit_pkg::flit_t [`NOC_NUM_PORTS-1:0]     head_flit;
  logic [`NOC_NUM_PORTS-1:0]                    read;

  logic [`NOC_NUM_PORTS-1:0]                    grant_valid;
  noc_route_pkg::port_oh_t [`NOC_NUM_PORTS-1:0] grant_in_oh;
  noc_route_pkg::port_oh_t                      lock;
  noc_route_pkg::port_oh_t                      sent;
  noc_route_pkg::vc_id_t [`NOC_NUM_PORTS-1:0]   sent_vc;

  logic [`NOC_NUM_PORTS-1:0]                    vc_free_valid;
  noc_route_pkg::vc_id_t [`NOC_NUM_PORTS-1:0]   vc_free_id;
  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0]   vc_not_full;

  for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : gen_port
    vc_input_port i_input_port (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .data_valid_i   ( data_valid_i[p]   ),
      .data_i         ( data_i[p]         ),
      .read_i         ( read[p]           ),
      .req_valid_o    ( req_valid[p]      ),
      .req_port_oh_o  ( req_port_oh[p]    ),
      .req_last_o     ( req_last[p]       ),
      .head_flit_o    ( head_flit[p]      ),
      .credit_valid_o ( credit_valid_o[p] ),
      .credit_id_o    ( credit_id_o[p]    )
    );

    // Credits of the downstream router on this output
    out_credit_vc_sel i_credit (
      .clk_i           ( clk_i             ),
      .rst_n_i         ( rst_n_i           ),
      .credit_valid_i  ( credit_valid_i[p] ),
      .credit_id_i     ( credit_id_i[p]    ),
      .consume_i       ( sent[p]           ),
      .consume_id_i    ( sent_vc[p]        ),
      .vc_free_valid_o ( vc_free_valid[p]  ),
      .vc_free_id_o    ( vc_free_id[p]     ),
      .vc_not_full_o   ( vc_not_full[p]    )
    );
  end

  sw_alloc_global i_sw_alloc (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .req_valid_i   ( req_valid   ),
    .req_port_oh_i ( req_port_oh ),
    .req_last_i    ( req_last    ),
    .sent_i        ( sent        ),
    .grant_valid_o ( grant_valid ),
    .grant_in_oh_o ( grant_in_oh ),
    .lock_o        ( lock        )
  );

  vc_router_switch i_switch (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .grant_valid_i   ( grant_valid   ),
    .grant_in_oh_i   ( grant_in_oh   ),
    .lock_i          ( lock          ),
    .vc_free_valid_i ( vc_free_valid ),
    .vc_free_id_i    ( vc_free_id    ),
    .vc_not_full_i   ( vc_not_full   ),
    .head_flit_i     ( head_flit     ),
    .req_last_i      ( req_last      ),
    .sent_o          ( sent          ),
    .sent_vc_o       ( sent_vc       ),
    .read_o          ( read          ),
    .data_valid_o    ( data_valid_o  ),
    .data_o          ( data_o        )
  );

endmodule

// File: tb_vc_router.sv
/*
 * Testbench for the three-port VC router
 * Applies a table of packets, models downstream credits and checks delivery
 */
`timescale 1ns/1ps
`include "noc_config.svh"

module tb_vc_router;

  typedef struct packed {
    int in_port;
    int in_vc;
    int dst;
    int len;
    int tag;
    int exp_port;
    int grp;
    int hold;
  } row_t;

  localparam int num_rows   = 10;
  localparam int num_groups = 7;
  localparam int max_len    = 8;
  localparam int np         = `NOC_NUM_PORTS;
  localparam int nv         = `NOC_NUM_VC;
  localparam int depth      = `NOC_VC_DEPTH;
  localparam longint watchdog_ns = (num_rows * 4 * 40 + 10) * 100;

  // in port, in vc, dst, length, tag, expected port, group, withhold credits
  // Rows of one group are sent side by side
  row_t rows [num_rows] = '{
    '{0, 0, 1, 3, 'h101, 1, 0, 0},
    '{1, 1, 2, 1, 'h102, 2, 1, 0},
    '{2, 0, 0, 4, 'h103, 0, 2, 0},
    '{0, 0, 2, 5, 'h104, 2, 3, 0},
    '{1, 0, 2, 5, 'h105, 2, 3, 0},
    '{0, 1, 1, 6, 'h106, 1, 4, 1},
    '{0, 0, 2, 3, 'h107, 2, 5, 0},
    '{1, 1, 0, 4, 'h108, 0, 5, 0},
    '{2, 1, 1, 2, 'h109, 1, 5, 0},
    '{2, 0, 2, 2, 'h10a, 2, 6, 0}
  };

  logic                           clk_i = 1'b0;
  logic                           rst_n_i;
  logic [np-1:0]                  data_valid_i;
  noc_flit_pkg::flit_t [np-1:0]   data_i;
  logic [np-1:0]                  credit_valid_i = '0;
  noc_route_pkg::vc_id_t [np-1:0] credit_id_i = '0;
  logic [np-1:0]                  data_valid_o;
  noc_flit_pkg::flit_t [np-1:0]   data_o;
  logic [np-1:0]                  credit_valid_o;
  noc_route_pkg::vc_id_t [np-1:0] credit_id_o;

  integer                 seed = 84909;
  logic [`NOC_DATA_W-1:0] exp_word [num_rows][max_len];
  int                     next_idx [num_rows];
  int                     rcv_idx [num_rows];
  int                     row_err [num_rows];
  logic                   row_done [num_rows];
  int                     cur_row [np];
  int                     pkt_vc [np];
  int                     sent_cnt [np][nv];
  int                     ret_cnt [np][nv];
  int                     out_sent [np][nv];
  int                     out_ret [np][nv];
  int                     cred_vc_q [np][$];
  longint                 cred_due_q [np][$];
  logic [np-1:0]          withhold = '0;
  int                     cur_grp = -1;
  int                     reset_err = 0;
  int                     misc_err = 0;
  int                     tests_run = 0;
  int                     tests_fail = 0;

  always #50 clk_i = ~clk_i;

  vc_router UUT (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .data_valid_i   ( data_valid_i   ),
    .data_i         ( data_i         ),
    .credit_valid_i ( credit_valid_i ),
    .credit_id_i    ( credit_id_i    ),
    .data_valid_o   ( data_valid_o   ),
    .data_o         ( data_o         ),
    .credit_valid_o ( credit_valid_o ),
    .credit_id_o    ( credit_id_o    )
  );

  ////////////////////////////////////////
  // Downstream model
  ////////////////////////////////////////

  // One credit per output and cycle once its delay has run out
  always @(posedge clk_i) begin
    for (int o = 0; o < np; o++) begin
      if (rst_n_i && !withhold[o] && cred_vc_q[o].size() > 0 &&
          cred_due_q[o][0] <= $time) begin
        credit_valid_i[o] <= 1'b1;
        credit_id_i[o]    <= noc_route_pkg::vc_id_t'(cred_vc_q[o][0]);
        out_ret[o][cred_vc_q[o][0]]++;
        void'(cred_vc_q[o].pop_front());
        void'(cred_due_q[o].pop_front());
      end else begin
        credit_valid_i[o] <= 1'b0;
      end
    end
  end

  task automatic check_flit(input int o, input noc_flit_pkg::flit_t f);
    int r;
    int idx;
    int vc;
    r = cur_row[o];
    if (r < 0) begin
      for (int k = 0; k < num_rows; k++) begin
        if (!row_done[k] && rows[k].grp == cur_grp && rows[k].exp_port == o &&
            rcv_idx[k] == 0 && f.data.head.tag == `NOC_TAG_W'(rows[k].tag)) begin
          r = k;
        end
      end
      if (r < 0) begin
        $display("output %0d delivered a head flit that matches no packet in flight", o);
        misc_err++;
        return;
      end
      cur_row[o] = r;
      pkt_vc[o]  = int'(f.vc_id);
    end
    idx = rcv_idx[r];
    vc  = int'(f.vc_id);
    if (f.data.payload !== exp_word[r][idx]) begin
      $display("** Error data_o[%0d].data: got 0x%h expected 0x%h",
               o, f.data.payload, exp_word[r][idx]);
      row_err[r]++;
    end
    if (f.last !== (idx == rows[r].len - 1)) begin
      $display("** Error data_o[%0d].last: got 0x%h expected 0x%h",
               o, f.last, (idx == rows[r].len - 1));
      row_err[r]++;
    end
    if (vc != pkt_vc[o]) begin
      $display("** Error data_o[%0d].vc_id: got 0x%h expected 0x%h", o, vc, pkt_vc[o]);
      row_err[r]++;
    end
    out_sent[o][vc]++;
    if (out_sent[o][vc] - out_ret[o][vc] > depth) begin
      $display("output %0d vc %0d sent more flits than downstream has slots", o, vc);
      row_err[r]++;
    end
    cred_vc_q[o].push_back(vc);
    cred_due_q[o].push_back($time + 100 * (1 + ($unsigned($random(seed)) % 4)));
    rcv_idx[r]++;
    if (rcv_idx[r] == rows[r].len) begin
      cur_row[o]  = -1;
      row_done[r] = 1'b1;
      tests_run++;
      if (row_err[r] != 0) tests_fail++;
      $display("test %0d: input %0d vc %0d to port %0d, %0d flits: %s", r, rows[r].in_port,
               rows[r].in_vc, o, rows[r].len, (row_err[r] == 0) ? "ok" : "FAILED");
    end
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      if (data_valid_o !== '0 || credit_valid_o !== '0) begin
        $display("** Error data_valid_o/credit_valid_o in reset: got 0x%h/0x%h expected 0x0",
                 data_valid_o, credit_valid_o);
        reset_err++;
      end
    end else begin
      for (int p = 0; p < np; p++) begin
        if (credit_valid_o[p]) ret_cnt[p][credit_id_o[p]]++;
      end
      for (int o = 0; o < np; o++) begin
        if (data_valid_o[o]) check_flit(o, data_o[o]);
      end
    end
  end

  ////////////////////////////////////////
  // Upstream driver
  ////////////////////////////////////////

  // Sends the next flit of a row while a credit for its VC is held
  task automatic send_next_flit(input int r);
    int p;
    int v;
    int idx;
    noc_flit_pkg::flit_t f;
    p   = rows[r].in_port;
    v   = rows[r].in_vc;
    idx = next_idx[r];
    if (idx < rows[r].len && sent_cnt[p][v] - ret_cnt[p][v] < depth) begin
      f       = '0;
      f.last  = (idx == rows[r].len - 1);
      f.vc_id = v[0];
      if (idx == 0) begin
        f.data.head.dst_port = `NOC_PORT_W'(rows[r].dst);
        f.data.head.tag      = `NOC_TAG_W'(rows[r].tag);
      end else begin
        f.data.payload = exp_word[r][idx];
      end
      data_valid_i[p] <= 1'b1;
      data_i[p]       <= f;
      sent_cnt[p][v]++;
      next_idx[r]++;
    end
  endtask

  task automatic wait_drain();
    int busy;
    busy = 1;
    while (busy != 0) begin
      @(negedge clk_i);
      busy = 0;
      for (int o = 0; o < np; o++) begin
        busy += cred_vc_q[o].size();
      end
    end
  endtask

  initial begin
    int active;
    int stall;
    int cred_err;
    rst_n_i      = 1'b0;
    data_valid_i = '0;
    data_i       = '0;
    for (int r = 0; r < num_rows; r++) begin
      exp_word[r][0] = {`NOC_PORT_W'(rows[r].dst), `NOC_TAG_W'(rows[r].tag)};
      for (int k = 1; k < max_len; k++) begin
        exp_word[r][k] = `NOC_DATA_W'($random(seed));
      end
      next_idx[r] = 0;
      rcv_idx[r]  = 0;
      row_err[r]  = 0;
      row_done[r] = 1'b0;
    end
    for (int p = 0; p < np; p++) begin
      cur_row[p] = -1;
      pkt_vc[p]  = 0;
      for (int v = 0; v < nv; v++) begin
        sent_cnt[p][v] = 0;
        ret_cnt[p][v]  = 0;
        out_sent[p][v] = 0;
        out_ret[p][v]  = 0;
      end
    end

    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    tests_run++;
    if (reset_err != 0) tests_fail++;
    $display("test reset: outputs low for 10 cycles: %s", (reset_err == 0) ? "ok" : "FAILED");

    for (int g = 0; g < num_groups; g++) begin
      wait_drain();
      @(posedge clk_i);
      cur_grp = g;
      stall   = 0;
      for (int r = 0; r < num_rows; r++) begin
        if (rows[r].grp == g && rows[r].hold != 0) withhold[rows[r].exp_port] <= 1'b1;
      end
      active = 1;
      while (active != 0) begin
        data_valid_i <= '0;
        active = 0;
        for (int r = 0; r < num_rows; r++) begin
          if (rows[r].grp == g) begin
            if (!row_done[r]) active = 1;
            send_next_flit(r);
            // Held output stalls after one VC's worth of credits
            if (rows[r].hold != 0 && withhold[rows[r].exp_port] && rcv_idx[r] >= depth) begin
              stall++;
              if (stall == 20) begin
                if (rcv_idx[r] != depth) begin
                  $display("** Error data_valid_o[%0d] held count: got 0x%h expected 0x%h",
                           rows[r].exp_port, rcv_idx[r], depth);
                  row_err[r]++;
                end
                withhold[rows[r].exp_port] <= 1'b0;
              end
            end
          end
        end
        @(posedge clk_i);
      end
    end

    wait_drain();
    repeat (2) @(negedge clk_i);
    cred_err = 0;
    for (int p = 0; p < np; p++) begin
      for (int v = 0; v < nv; v++) begin
        if (ret_cnt[p][v] != sent_cnt[p][v]) begin
          $display("** Error credit_valid_o[%0d] count for vc %0d: got 0x%h expected 0x%h",
                   p, v, ret_cnt[p][v], sent_cnt[p][v]);
          cred_err++;
        end
      end
    end
    tests_run++;
    if (cred_err != 0) tests_fail++;
    $display("test credits: returned per input VC: %s", (cred_err == 0) ? "ok" : "FAILED");
    $display("%0d tests run, %0d passed, %0d failed, %0d stray flits",
             tests_run, tests_run - tests_fail, tests_fail, misc_err);
    if (tests_fail == 0 && misc_err == 0 && tests_run == num_rows + 2) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before all packets were delivered");
    $display("tests failed");
    $finish;
  end

endmodule

// File: vc_router.f
+incdir+.
noc_flit_pkg.sv
noc_route_pkg.sv
vc_input_port.sv
sw_alloc_global.sv
out_credit_vc_sel.sv
vc_router_switch.sv
vc_router.sv
tb_vc_router.sv

// File: run_sim.sh
#!/bin/sh
# Build the router testbench with Verilator, run it and check the result

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_vc_router \
  -f vc_router.f -o sim_vc_router || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_vc_router)
echo "$out"

echo "$out" | grep -q "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

exit 0
